//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_aes_kv
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/aes_edn_arbiter.sv
// Entropy request arbiter for the clearing and masking PRNGs
// Clearing has priority, the shared request is held until acknowledged

`timescale 1ns/1ps

module aes_edn_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  aes_kv_pkg::edn_req_t  req_i,
  input  logic                  edn_ack_i,
  output logic                  edn_req_o,
  output aes_kv_pkg::edn_ack_t  ack_o
);

  logic req_any;
  logic hold_d, hold_q;

  assign req_any = req_i.clearing_req | req_i.masking_req;

  // A request dropped early stays asserted toward the source until its ack
  assign edn_req_o = req_any | hold_q;
  assign hold_d    = (hold_q | edn_req_o) & ~edn_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= hold_d;
    end
  end

  // Ack goes only to a PRNG that is requesting right now
  assign ack_o.clearing_ack = req_i.clearing_req & edn_ack_i;
  assign ack_o.masking_ack  = ~req_i.clearing_req & req_i.masking_req & edn_ack_i;

endmodule

//--- rtl/aes_kv_capture.sv
// Key-vault capture engine
// Capture FSM, wrapping chunk counter and the key-vault buffer

`timescale 1ns/1ps

module aes_kv_capture #(
  parameter int unsigned NumChunks = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  aes_kv_pkg::decode_evt_t                  evt_i,
  input  aes_kv_pkg::core_out_t                    core_out_i,
  output logic                                     intercept_o,
  output aes_kv_pkg::block_t [NumChunks-1:0]       kv_data_o,
  output logic                                     kv_valid_o
);

  localparam int unsigned CntWidth = $clog2(NumChunks);

  aes_kv_pkg::capture_state_e         state_d, state_q;
  logic [CntWidth-1:0]                chunk_cnt_q;
  aes_kv_pkg::block_t [NumChunks-1:0] kv_buf_q;
  logic                               start_accept;
  logic                               store_en;
  logic                               clear_buf;

  // While the buffer is held for the client, new starts are not taken
  assign start_accept = (evt_i.start_kv | evt_i.start_plain) &
                        (state_q != aes_kv_pkg::CAP_HOLD);
  assign store_en     = (state_q == aes_kv_pkg::CAP_RUN) & core_out_i.valid & ~start_accept;
  assign clear_buf    = (state_q == aes_kv_pkg::CAP_HOLD) & evt_i.kv_done;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      aes_kv_pkg::CAP_IDLE: begin
        if (evt_i.start_kv) begin
          state_d = aes_kv_pkg::CAP_RUN;
        end
      end
      aes_kv_pkg::CAP_RUN: begin
        if (evt_i.start_plain) begin
          state_d = aes_kv_pkg::CAP_IDLE;
        end else if (!evt_i.start_kv && evt_i.idle_rise) begin
          // Core finished, buffer is complete
          state_d = aes_kv_pkg::CAP_HOLD;
        end
      end
      aes_kv_pkg::CAP_HOLD: begin
        if (evt_i.kv_done) begin
          state_d = aes_kv_pkg::CAP_IDLE;
        end
      end
      default: begin
        state_d = aes_kv_pkg::CAP_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= aes_kv_pkg::CAP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // Chunk counter
  ////////////////////

  // Wraps by design when the core emits more blocks than there are slots
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chunk_cnt_q <= '0;
    end else if (start_accept) begin
      chunk_cnt_q <= '0;
    end else if (store_en) begin
      chunk_cnt_q <= chunk_cnt_q + 1'b1;
    end
  end

  ////////////////////
  // Key-vault buffer
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      kv_buf_q <= '0;
    end else if (clear_buf) begin
      kv_buf_q <= '0;
    end else if (store_en) begin
      kv_buf_q[chunk_cnt_q] <= core_out_i.data;
    end
  end

  assign intercept_o = (state_q == aes_kv_pkg::CAP_RUN);
  assign kv_valid_o  = (state_q == aes_kv_pkg::CAP_HOLD);
  assign kv_data_o   = kv_buf_q;

endmodule

//--- rtl/aes_kv_decode.sv
// Host command decoder and core idle edge detector
// Produces registered one-cycle event pulses for the capture engine

`timescale 1ns/1ps

module aes_kv_decode (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  aes_kv_pkg::cmd_t         cmd_i,
  input  logic                     core_idle_i,
  output aes_kv_pkg::decode_evt_t  evt_o
);

  aes_kv_pkg::decode_evt_t evt_d, evt_q;
  logic                    idle_prev_q;

  ////////////////////
  // Command decode
  ////////////////////

  always_comb begin
    evt_d = '0;
    if (cmd_i.valid) begin
      unique case (cmd_i.op)
        aes_kv_pkg::CMD_START: begin
          evt_d.start_plain = 1'b1;
        end
        aes_kv_pkg::CMD_START_KV: begin
          evt_d.start_kv = 1'b1;
        end
        aes_kv_pkg::CMD_KV_DONE: begin
          evt_d.kv_done = 1'b1;
        end
        default: begin
          // CMD_NOP
          evt_d.start_plain = 1'b0;
        end
      endcase
    end

    // Idle edges against the level seen on the previous edge
    evt_d.idle_rise = core_idle_i & ~idle_prev_q;
    evt_d.idle_fall = ~core_idle_i & idle_prev_q;
  end

  ////////////////////
  // Registers
  ////////////////////

  // Core is assumed idle out of reset, so no edge is reported at startup
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idle_prev_q <= 1'b1;
    end else begin
      idle_prev_q <= core_idle_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_q <= '0;
    end else begin
      evt_q <= evt_d;
    end
  end

  assign evt_o = evt_q;

endmodule

//--- rtl/aes_kv_output.sv
// Software output path
// Conceals core data from software reads and routes the core read acknowledge

`timescale 1ns/1ps

module aes_kv_output (
  input  logic                   intercept_i,
  input  aes_kv_pkg::core_out_t  core_out_i,
  input  logic                   sw_read_i,
  output logic                   core_read_o,
  output aes_kv_pkg::block_t     sw_data_o
);

  always_comb begin
    if (intercept_i) begin
      // Key-vault mode acknowledges every block itself and hides the data
      core_read_o = core_out_i.valid;
      sw_data_o   = '0;
    end else begin
      // Software mode, the core holds its block until software reads it
      core_read_o = sw_read_i;
      sw_data_o   = core_out_i.data;
    end
  end

endmodule

//--- rtl/aes_kv_pkg.sv
// Shared widths, command and capture state encodings
// Packed structs for core output, host command, decode events and entropy

package aes_kv_pkg;

  ////////////////////
  // Widths
  ////////////////////

  parameter int unsigned DataWidth    = 32;
  parameter int unsigned NumDataWords = 4;
  parameter int unsigned BlockWidth   = DataWidth * NumDataWords;
  parameter int unsigned EntropyWidth = 32;

  typedef logic [BlockWidth-1:0] block_t;

  ////////////////////
  // Encodings
  ////////////////////

  // Host command opcodes
  typedef enum logic [1:0] {
    CMD_NOP      = 2'b00,
    CMD_START    = 2'b01,
    CMD_START_KV = 2'b10,
    CMD_KV_DONE  = 2'b11
  } cmd_op_e;

  // Capture engine states
  typedef enum logic [1:0] {
    CAP_IDLE = 2'b00,
    CAP_RUN  = 2'b01,
    CAP_HOLD = 2'b10
  } capture_state_e;

  ////////////////////
  // Bundles
  ////////////////////

  // One output block from the cipher core
  typedef struct packed {
    logic   valid;
    block_t data;
  } core_out_t;

  typedef struct packed {
    logic    valid;
    cmd_op_e op;
  } cmd_t;

  // Single-cycle pulses from decode to capture
  typedef struct packed {
    logic start_kv;
    logic start_plain;
    logic kv_done;
    logic idle_rise;
    logic idle_fall;
  } decode_evt_t;

  typedef struct packed {
    logic clearing_req;
    logic masking_req;
  } edn_req_t;

  typedef struct packed {
    logic clearing_ack;
    logic masking_ack;
  } edn_ack_t;

endpackage

//--- rtl/aes_kv_top.sv
// Key-vault wrapper top level
// Command decode, capture engine, software output path and entropy arbiter

`timescale 1ns/1ps

module aes_kv_top #(
  parameter int unsigned NumChunks = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Host command and cipher core side
  input  aes_kv_pkg::cmd_t                    cmd_i,
  input  aes_kv_pkg::core_out_t               core_out_i,
  input  logic                                core_idle_i,
  output logic                                core_read_o,

  // Software read path
  input  logic                                sw_read_i,
  output aes_kv_pkg::block_t                  sw_data_o,

  // Key-vault client
  output aes_kv_pkg::block_t [NumChunks-1:0]  kv_data_o,
  output logic                                kv_valid_o,

  // Entropy port
  input  aes_kv_pkg::edn_req_t                edn_req_i,
  input  logic                                edn_ack_i,
  output logic                                edn_req_o,
  output aes_kv_pkg::edn_ack_t                edn_ack_o
);

  aes_kv_pkg::decode_evt_t decode_evt;
  logic                    intercept;

  ////////////////////
  // Key-vault path
  ////////////////////

  aes_kv_decode u_decode (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .cmd_i       ( cmd_i       ),
    .core_idle_i ( core_idle_i ),
    .evt_o       ( decode_evt  )
  );

  aes_kv_capture #(
    .NumChunks ( NumChunks )
  ) u_capture (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .evt_i       ( decode_evt  ),
    .core_out_i  ( core_out_i  ),
    .intercept_o ( intercept   ),
    .kv_data_o   ( kv_data_o   ),
    .kv_valid_o  ( kv_valid_o  )
  );

  aes_kv_output u_output (
    .intercept_i ( intercept   ),
    .core_out_i  ( core_out_i  ),
    .sw_read_i   ( sw_read_i   ),
    .core_read_o ( core_read_o ),
    .sw_data_o   ( sw_data_o   )
  );

  ////////////////////
  // Entropy
  ////////////////////

  aes_edn_arbiter u_edn (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .req_i     ( edn_req_i ),
    .edn_ack_i ( edn_ack_i ),
    .edn_req_o ( edn_req_o ),
    .ack_o     ( edn_ack_o )
  );

endmodule

//--- testbench/aes_kv_checker.sv
// Scoreboard for the key-vault wrapper
// Reference model of the decode, capture, output and entropy rules, compared every cycle

`timescale 1ns/1ps

module aes_kv_checker #(
  parameter int unsigned NumChunks = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  aes_kv_pkg::cmd_t                    cmd_i,
  input  aes_kv_pkg::core_out_t               core_out_i,
  input  logic                                core_idle_i,
  input  logic                                sw_read_i,
  input  aes_kv_pkg::edn_req_t                edn_req_i,
  input  logic                                edn_ack_i,
  input  logic                                core_read_i,
  input  aes_kv_pkg::block_t                  sw_data_i,
  input  aes_kv_pkg::block_t [NumChunks-1:0]  kv_data_i,
  input  logic                                kv_valid_i,
  input  logic                                edn_req_out_i,
  input  aes_kv_pkg::edn_ack_t                edn_ack_out_i,
  input  logic                                exp_en_i,
  input  int unsigned                         exp_slot_i,
  input  aes_kv_pkg::block_t                  exp_data_i,
  output int unsigned                         err_count_o
);

  logic                               ev_kv, ev_plain, ev_done, ev_rise, idle_prev;
  aes_kv_pkg::capture_state_e         state;
  int unsigned                        slot;
  aes_kv_pkg::block_t [NumChunks-1:0] model_buf;
  logic                               req_pending;
  int unsigned                        err_count = 0;
  logic                               intercept_exp;
  aes_kv_pkg::edn_ack_t               ack_exp;

  ////////////////////
  // Reference model
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {ev_kv, ev_plain, ev_done, ev_rise} <= '0;
      idle_prev   <= 1'b1;
      state       <= aes_kv_pkg::CAP_IDLE;
      slot        <= 0;
      model_buf   <= '0;
      req_pending <= 1'b0;
    end else begin
      // Command and idle edge seen one cycle later
      ev_kv     <= cmd_i.valid && (cmd_i.op == aes_kv_pkg::CMD_START_KV);
      ev_plain  <= cmd_i.valid && (cmd_i.op == aes_kv_pkg::CMD_START);
      ev_done   <= cmd_i.valid && (cmd_i.op == aes_kv_pkg::CMD_KV_DONE);
      ev_rise   <= core_idle_i && !idle_prev;
      idle_prev <= core_idle_i;
      if (state == aes_kv_pkg::CAP_HOLD) begin
        if (ev_done) begin
          state     <= aes_kv_pkg::CAP_IDLE;
          model_buf <= '0;
        end
      end else if (ev_kv) begin
        state <= aes_kv_pkg::CAP_RUN;
        slot  <= 0;
      end else if (ev_plain) begin
        state <= aes_kv_pkg::CAP_IDLE;
        slot  <= 0;
      end else if (state == aes_kv_pkg::CAP_RUN) begin
        if (core_out_i.valid) begin
          model_buf[slot] <= core_out_i.data;
          slot            <= (slot + 1) % NumChunks;
        end
        if (ev_rise) begin
          state <= aes_kv_pkg::CAP_HOLD;
        end
      end
      // Any request not yet acknowledged stays pending
      req_pending <= (req_pending | edn_req_i.clearing_req | edn_req_i.masking_req) & ~edn_ack_i;
    end
  end

  // Clearing wins the ack whenever it requests, masking gets it otherwise
  always_comb begin
    ack_exp = '0;
    if (edn_ack_i) begin
      if (edn_req_i.clearing_req) begin
        ack_exp.clearing_ack = 1'b1;
      end else if (edn_req_i.masking_req) begin
        ack_exp.masking_ack = 1'b1;
      end
    end
  end

  assign intercept_exp = (state == aes_kv_pkg::CAP_RUN);
  assign err_count_o   = err_count;

  ////////////////////
  // Comparison
  ////////////////////

  task automatic compare(input string what, input aes_kv_pkg::block_t got,
                         input aes_kv_pkg::block_t exp);
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Outputs are settled half a cycle after the driving edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      compare("core_read_o", aes_kv_pkg::block_t'(core_read_i),
              aes_kv_pkg::block_t'(intercept_exp ? core_out_i.valid : sw_read_i));
      compare("sw_data_o", sw_data_i, intercept_exp ? '0 : core_out_i.data);
      compare("kv_valid_o", aes_kv_pkg::block_t'(kv_valid_i),
              aes_kv_pkg::block_t'(state == aes_kv_pkg::CAP_HOLD));
      compare("edn_req_o", aes_kv_pkg::block_t'(edn_req_out_i),
              aes_kv_pkg::block_t'(edn_req_i.clearing_req | edn_req_i.masking_req |
                                   req_pending));
      compare("edn_ack_o.clearing_ack", aes_kv_pkg::block_t'(edn_ack_out_i.clearing_ack),
              aes_kv_pkg::block_t'(ack_exp.clearing_ack));
      compare("edn_ack_o.masking_ack", aes_kv_pkg::block_t'(edn_ack_out_i.masking_ack),
              aes_kv_pkg::block_t'(ack_exp.masking_ack));
      for (int i = 0; i < NumChunks; i++) begin
        compare($sformatf("kv_data_o[%0d]", i), kv_data_i[i], model_buf[i]);
      end
      if (exp_en_i) begin
        compare($sformatf("kv_data_o[%0d] from file", exp_slot_i),
                kv_data_i[exp_slot_i], exp_data_i);
      end
    end
  end

endmodule

//--- testbench/aes_kv_props.sv
// Concurrent assertions on the key-vault wrapper, bound into the top level

`timescale 1ns/1ps

module aes_kv_props (
  input logic                    clk_i,
  input logic                    rst_ni,
  input aes_kv_pkg::decode_evt_t evt_i,
  input logic                    kv_valid_i,
  input logic                    core_read_i,
  input logic                    intercept_i,
  input logic                    sw_read_i,
  input logic                    edn_req_out_i,
  input logic                    edn_ack_i
);

  // Buffer is released only by the client's done command
  kv_valid_fall_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(kv_valid_i) |-> $past(evt_i.kv_done))
    else $error("kv_valid_o fell without a kv_done event");

  read_source_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_read_i |-> (intercept_i || sw_read_i))
    else $error("core_read_o high with neither intercept nor software read");

  edn_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (edn_req_out_i && !edn_ack_i) |=> edn_req_out_i)
    else $error("edn_req_o dropped before its acknowledge");

endmodule

bind aes_kv_top aes_kv_props u_props (
  .clk_i         ( clk_i       ),
  .rst_ni        ( rst_ni      ),
  .evt_i         ( decode_evt  ),
  .kv_valid_i    ( kv_valid_o  ),
  .core_read_i   ( core_read_o ),
  .intercept_i   ( intercept   ),
  .sw_read_i     ( sw_read_i   ),
  .edn_req_out_i ( edn_req_o   ),
  .edn_ack_i     ( edn_ack_i   )
);

//--- testbench/aes_kv_tests.txt
# S cmd_valid cmd_op core_valid core_data core_idle sw_read clr_req msk_req edn_ack (hex)
# K slot data waits for kv_valid_o, C slot data checks at once; op 1 START 2 START_KV 3 KV_DONE
S 1 1 0 0 1 0 1 1 0
S 0 0 0 0 0 0 1 1 1
S 0 0 1 a0a0a0a0a0a0a0a0a0a0a0a0a0a0a0a0 0 0 0 1 1
S 0 0 1 a0a0a0a0a0a0a0a0a0a0a0a0a0a0a0a0 0 1 0 1 0
S 0 0 0 0 1 0 0 0 0
S 1 2 0 0 1 0 0 0 0
S 0 0 0 0 0 0 0 0 1
S 0 0 1 b0b0b0b0b0b0b0b0b0b0b0b0b0b0b0b0 0 0 0 0 0
S 0 0 1 b1b1b1b1b1b1b1b1b1b1b1b1b1b1b1b1 0 0 0 0 0
S 0 0 1 b2b2b2b2b2b2b2b2b2b2b2b2b2b2b2b2 0 0 0 0 0
S 0 0 1 b3b3b3b3b3b3b3b3b3b3b3b3b3b3b3b3 0 0 0 0 0
S 0 0 0 0 1 0 0 0 0
K 0 b0b0b0b0b0b0b0b0b0b0b0b0b0b0b0b0
K 1 b1b1b1b1b1b1b1b1b1b1b1b1b1b1b1b1
K 2 b2b2b2b2b2b2b2b2b2b2b2b2b2b2b2b2
K 3 b3b3b3b3b3b3b3b3b3b3b3b3b3b3b3b3
S 1 3 0 0 1 0 0 0 0
S 0 0 0 0 1 0 0 0 0
C 0 0
C 3 0
S 1 2 0 0 1 0 0 0 0
S 0 0 0 0 0 0 0 0 0
S 0 0 1 c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0 0 0 0 0 0
S 0 0 1 c1c1c1c1c1c1c1c1c1c1c1c1c1c1c1c1 0 0 0 0 0
S 0 0 1 c2c2c2c2c2c2c2c2c2c2c2c2c2c2c2c2 0 0 0 0 0
S 0 0 1 c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3 0 0 0 0 0
S 0 0 1 c4c4c4c4c4c4c4c4c4c4c4c4c4c4c4c4 0 0 0 0 0
S 0 0 0 0 1 0 0 0 0
K 0 c4c4c4c4c4c4c4c4c4c4c4c4c4c4c4c4
K 1 c1c1c1c1c1c1c1c1c1c1c1c1c1c1c1c1
K 2 c2c2c2c2c2c2c2c2c2c2c2c2c2c2c2c2
K 3 c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3
S 1 3 0 0 1 0 0 0 0
S 0 0 0 0 1 0 0 0 0
S 1 1 0 0 1 0 0 0 0
S 0 0 1 d0d0d0d0d0d0d0d0d0d0d0d0d0d0d0d0 0 0 0 0 0
S 0 0 1 d0d0d0d0d0d0d0d0d0d0d0d0d0d0d0d0 0 1 0 0 0
S 0 0 0 0 1 0 0 0 0
S 0 0 0 0 1 0 0 0 0
S 0 0 0 0 1 0 0 0 0

//--- testbench/tb_aes_kv.sv
// Testbench top for the key-vault wrapper
// Clock, reset, file-driven stimulus, DUT and checker instances, final report

`timescale 1ns/1ps

module tb_aes_kv;

  localparam int unsigned NumChunks = 4;
  localparam int unsigned WaitLimit = 40;
  localparam string       TestFile  = "testbench/aes_kv_tests.txt";

  logic                               clk;
  logic                               rst_n;
  aes_kv_pkg::cmd_t                   cmd;
  aes_kv_pkg::core_out_t              core_out;
  logic                               core_idle;
  logic                               core_read;
  logic                               sw_read;
  aes_kv_pkg::block_t                 sw_data;
  aes_kv_pkg::block_t [NumChunks-1:0] kv_data;
  logic                               kv_valid;
  aes_kv_pkg::edn_req_t               edn_req;
  logic                               edn_ack;
  logic                               edn_req_out;
  aes_kv_pkg::edn_ack_t               edn_ack_out;
  logic                               exp_en;
  int unsigned                        exp_slot;
  aes_kv_pkg::block_t                 exp_data;
  int unsigned                        err_count;
  int unsigned                        timeout_count;
  int unsigned                        bad_lines;

  always #20 clk = ~clk;

  aes_kv_top #(
    .NumChunks ( NumChunks )
  ) uut (
    .clk_i       ( clk         ),
    .rst_ni      ( rst_n       ),
    .cmd_i       ( cmd         ),
    .core_out_i  ( core_out    ),
    .core_idle_i ( core_idle   ),
    .core_read_o ( core_read   ),
    .sw_read_i   ( sw_read     ),
    .sw_data_o   ( sw_data     ),
    .kv_data_o   ( kv_data     ),
    .kv_valid_o  ( kv_valid    ),
    .edn_req_i   ( edn_req     ),
    .edn_ack_i   ( edn_ack     ),
    .edn_req_o   ( edn_req_out ),
    .edn_ack_o   ( edn_ack_out )
  );

  aes_kv_checker #(
    .NumChunks ( NumChunks )
  ) u_checker (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .cmd_i         ( cmd         ),
    .core_out_i    ( core_out    ),
    .core_idle_i   ( core_idle   ),
    .sw_read_i     ( sw_read     ),
    .edn_req_i     ( edn_req     ),
    .edn_ack_i     ( edn_ack     ),
    .core_read_i   ( core_read   ),
    .sw_data_i     ( sw_data     ),
    .kv_data_i     ( kv_data     ),
    .kv_valid_i    ( kv_valid    ),
    .edn_req_out_i ( edn_req_out ),
    .edn_ack_out_i ( edn_ack_out ),
    .exp_en_i      ( exp_en      ),
    .exp_slot_i    ( exp_slot    ),
    .exp_data_i    ( exp_data    ),
    .err_count_o   ( err_count   )
  );

  ////////////////////
  // Stimulus
  ////////////////////

  // One S line drives all inputs for one clock cycle
  task automatic apply_line(input string line);
    string              tag;
    logic [3:0]         cv, op, cval, idle, rd, creq, mreq, ack;
    aes_kv_pkg::block_t data;
    int                 n;
    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h",
                tag, cv, op, cval, data, idle, rd, creq, mreq, ack);
    if (n != 10) begin
      bad_lines++;
      $display("Malformed stimulus line: %s", line);
    end else begin
      @(posedge clk);
      cmd.valid             <= cv[0];
      cmd.op                <= aes_kv_pkg::cmd_op_e'(op[1:0]);
      core_out.valid        <= cval[0];
      core_out.data         <= data;
      core_idle             <= idle[0];
      sw_read               <= rd[0];
      edn_req.clearing_req  <= creq[0];
      edn_req.masking_req   <= mreq[0];
      edn_ack               <= ack[0];
      exp_en                <= 1'b0;
    end
  endtask

  // K lines wait for kv_valid_o first, C lines present their slot at once
  task automatic present_slot(input string line, input logic wait_valid, output logic ok);
    string              tag;
    int unsigned        slot;
    aes_kv_pkg::block_t data;
    int unsigned        cycles;
    int                 n;
    ok = 1'b1;
    n  = $sscanf(line, "%s %d %h", tag, slot, data);
    if (n != 3) begin
      bad_lines++;
      $display("Malformed expectation line: %s", line);
    end else begin
      cycles = 0;
      @(negedge clk);
      while (wait_valid && !kv_valid && cycles < WaitLimit) begin
        @(negedge clk);
        cycles++;
      end
      if (wait_valid && !kv_valid) begin
        ok = 1'b0;
        timeout_count++;
        $display("Timeout: kv_valid_o never rose before checking slot %0d", slot);
      end else begin
        @(posedge clk);
        cmd.valid <= 1'b0;
        exp_en    <= 1'b1;
        exp_slot  <= slot;
        exp_data  <= data;
      end
    end
  endtask

  initial begin
    int    fd;
    string line;
    logic  ok;
    clk           = 1'b0;
    rst_n         = 1'b0;
    cmd           = '0;
    core_out      = '0;
    core_idle     = 1'b1;
    sw_read       = 1'b0;
    edn_req       = '0;
    edn_ack       = 1'b0;
    exp_en        = 1'b0;
    exp_slot      = 0;
    exp_data      = '0;
    timeout_count = 0;
    bad_lines     = 0;
    fd = $fopen(TestFile, "r");
    if (fd == 0) begin
      bad_lines++;
      $display("Could not open the stimulus file %s", TestFile);
    end else begin
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      ok = 1'b1;
      while (ok && !$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
          if (line[0] == "S") begin
            apply_line(line);
          end else if (line[0] == "K" || line[0] == "C") begin
            present_slot(line, line[0] == "K", ok);
          end else begin
            bad_lines++;
            $display("Unknown line kind in stimulus file: %s", line);
          end
        end
      end
      $fclose(fd);
      repeat (2) @(posedge clk);
    end
    $display("Closing report: %0d mismatches, %0d timeouts, %0d bad file lines",
             err_count, timeout_count, bad_lines);
    if (err_count == 0 && timeout_count == 0 && bad_lines == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
rtl/aes_kv_pkg.sv
rtl/aes_kv_decode.sv
rtl/aes_kv_capture.sv
rtl/aes_kv_output.sv
rtl/aes_edn_arbiter.sv
rtl/aes_kv_top.sv
testbench/aes_kv_checker.sv
testbench/aes_kv_props.sv
testbench/tb_aes_kv.sv
